// ==== flow_standby_i2c.sv ====
// Standby flow engine: packs, unpacks and reports legacy I2C transfers over TTI
`timescale 1ns/10ps
`include "i3c_standby_params.svh"

module flow_standby_i2c
  import i3c_standby_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  acq_valid_i,
  output logic                  acq_ready_o,
  input  logic [`ACQ_WIDTH-1:0] acq_data_i,
  output logic                  tx_valid_o,
  input  logic                  tx_ready_i,
  output logic [7:0]            tx_byte_o,
  tti_if.engine                 tti,
  input  logic                  enable_i,
  input  logic                  err_clear_i,
  output logic                  err_o,
  output logic                  xfer_done_o
);
  flow_state_e state_q;
  flow_state_e state_d;

  acq_id_e     acq_id;
  logic [7:0]  acq_byte;
  logic        acq_ok;
  logic        acq_take;

  logic [15:0] byte_cnt_q;
  logic [15:0] read_len_q;
  logic [31:0] dword_q;
  logic        is_read_q;
  logic        end_q;
  // Bit offset of the current byte lane in the dword buffer
  logic [4:0]  lane;

  logic        start_xfer;
  logic        store_byte;
  logic        push_done;
  logic        load_dword;
  logic        load_len;
  logic        cnt_inc;
  logic        set_end;

  assign acq_id   = acq_id_e'(acq_data_i[`ACQ_WIDTH-1:8]);
  assign acq_byte = acq_data_i[7:0];
  assign acq_ok   = acq_valid_i & enable_i;
  assign lane     = {byte_cnt_q[1:0], 3'b000};

  // Restart is never consumed mid-transfer, AwaitStart takes it as the next start
  assign acq_ready_o = enable_i & acq_take;

  assign tx_byte_o    = dword_q[lane +: 8];
  assign tti.rxd_data = dword_q;
  assign tti.rsp_data = resp_desc_t'{data_length: byte_cnt_q, is_read: is_read_q};

  assign err_o       = (state_q == ReportError);
  assign xfer_done_o = tti.rsp_valid & tti.rsp_ready;

  always_comb begin
    state_d       = state_q;
    acq_take      = 1'b0;
    tx_valid_o    = 1'b0;
    tti.cmd_ready = 1'b0;
    tti.txd_ready = 1'b0;
    tti.rxd_valid = 1'b0;
    tti.rsp_valid = 1'b0;
    start_xfer    = 1'b0;
    store_byte    = 1'b0;
    push_done     = 1'b0;
    load_dword    = 1'b0;
    load_len      = 1'b0;
    cnt_inc       = 1'b0;
    set_end       = 1'b0;

    unique case (state_q)
      AwaitStart: begin
        acq_take = 1'b1;
        // Stray events on an idle bus are dropped
        if (acq_ok && (acq_id == AcqStart || acq_id == AcqRestart)) begin
          start_xfer = 1'b1;
          state_d    = acq_byte[0] ? PopCommand : ReceiveByte;
        end
      end
      ReceiveByte: begin
        acq_take = (acq_id != AcqRestart);
        if (acq_ok) begin
          case (acq_id)
            AcqData: begin
              store_byte = 1'b1;
              cnt_inc    = 1'b1;
              if (byte_cnt_q[1:0] == 2'd3) begin
                state_d = PushDword;
              end
            end
            AcqStop, AcqRestart: begin
              set_end = 1'b1;
              state_d = (byte_cnt_q[1:0] != 2'd0) ? PushDword : PushResponse;
            end
            default: state_d = ReportError;
          endcase
        end
      end
      PushDword: begin
        tti.rxd_valid = 1'b1;
        if (tti.rxd_ready) begin
          push_done = 1'b1;
          state_d   = end_q ? PushResponse : ReceiveByte;
        end
      end
      PushResponse: begin
        tti.rsp_valid = 1'b1;
        if (tti.rsp_ready) begin
          state_d = AwaitStart;
        end
      end
      PopCommand: begin
        // Stop and restart wait until the read is complete
        acq_take      = (acq_id != AcqStop) && (acq_id != AcqRestart);
        tti.cmd_ready = 1'b1;
        if (acq_ok && acq_take) begin
          state_d = ReportError;
        end else if (tti.cmd_valid) begin
          load_len = 1'b1;
          state_d  = (tti.cmd_data.data_length == 16'd0) ? ReportError : PopDword;
        end
      end
      PopDword: begin
        acq_take      = (acq_id != AcqStop) && (acq_id != AcqRestart);
        tti.txd_ready = 1'b1;
        if (acq_ok && acq_take) begin
          state_d = ReportError;
        end else if (tti.txd_valid) begin
          load_dword = 1'b1;
          state_d    = SendByte;
        end
      end
      SendByte: begin
        acq_take   = (acq_id != AcqStop) && (acq_id != AcqRestart);
        tx_valid_o = 1'b1;
        if (acq_ok && acq_take) begin
          state_d = ReportError;
        end else if (tx_ready_i) begin
          cnt_inc = 1'b1;
          if (byte_cnt_q + 16'd1 == read_len_q) begin
            state_d = AwaitStop;
          end else if (byte_cnt_q[1:0] == 2'd3) begin
            state_d = PopDword;
          end
        end
      end
      AwaitStop: begin
        acq_take = (acq_id != AcqRestart);
        if (acq_ok) begin
          case (acq_id)
            AcqStop, AcqRestart: state_d = PushResponse;
            // Controller nacks the last byte of a read
            AcqNack: state_d = AwaitStop;
            default: state_d = ReportError;
          endcase
        end
      end
      ReportError: begin
        // Drain the bus side until software clears the error
        acq_take = 1'b1;
        if (err_clear_i) begin
          state_d = AwaitStart;
        end
      end
      default: state_d = ReportError;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= AwaitStart;
      byte_cnt_q <= '0;
      end_q      <= 1'b0;
    end else begin
      state_q <= state_d;
      if (start_xfer) begin
        byte_cnt_q <= '0;
        end_q      <= 1'b0;
      end else begin
        if (cnt_inc) begin
          byte_cnt_q <= byte_cnt_q + 16'd1;
        end
        if (set_end) begin
          end_q <= 1'b1;
        end
      end
    end
  end

  // Buffer is zeroed after each push so a partial dword has zero upper bytes
  always_ff @(posedge clk_i) begin
    if (start_xfer || push_done) begin
      dword_q <= '0;
    end else if (load_dword) begin
      dword_q <= tti.txd_data;
    end else if (store_byte) begin
      dword_q[lane +: 8] <= acq_byte;
    end
    if (start_xfer) begin
      is_read_q <= acq_byte[0];
    end
    if (load_len) begin
      read_len_q <= tti.cmd_data.data_length;
    end
  end

endmodule

// ==== i3c_standby_params.svh ====
// Standby bridge parameters: acquisition width, queue depth and register map
`ifndef I3C_STANDBY_PARAMS_SVH
`define I3C_STANDBY_PARAMS_SVH

// 3 id bits above 8 data bits
`define ACQ_WIDTH 11
`define QUEUE_DEPTH 8

`define REG_CTRL 2'd0
`define REG_STATUS 2'd1
`define REG_XFER_CNT 2'd2

`endif

// ==== i3c_standby_pkg.sv ====
// Standby bridge types: acquisition events, flow states and TTI descriptors
package i3c_standby_pkg;

  // Event kinds reported by the I2C target front end
  typedef enum logic [2:0] {
    AcqStart   = 3'd0,
    AcqRestart = 3'd1,
    AcqStop    = 3'd2,
    AcqData    = 3'd3,
    AcqNack    = 3'd4
  } acq_id_e;

  typedef enum logic [3:0] {
    AwaitStart   = 4'd0,
    ReceiveByte  = 4'd1,
    PushDword    = 4'd2,
    PushResponse = 4'd3,
    PopCommand   = 4'd4,
    PopDword     = 4'd5,
    SendByte     = 4'd6,
    AwaitStop    = 4'd7,
    ReportError  = 4'd8
  } flow_state_e;

  // Read command, length in bytes
  typedef struct packed {
    logic [15:0] data_length;
  } cmd_desc_t;

  // Transfer response
  typedef struct packed {
    logic [15:0] data_length;
    logic        is_read;
  } resp_desc_t;

endpackage

// ==== i3c_standby_sva.sv ====
// Handshake stability and reset checks for the standby flow engine
`timescale 1ns/10ps

module i3c_standby_sva
  import i3c_standby_pkg::*;
(
  input logic        clk_i,
  input logic        rst_ni,
  input logic        enable_i,
  input flow_state_e state_i,
  input logic        acq_ready_i,
  input logic        tx_valid_i,
  input logic        tx_ready_i,
  input logic [7:0]  tx_byte_i,
  input logic        rxd_valid_i,
  input logic        rxd_ready_i,
  input logic [31:0] rxd_data_i,
  input logic        rsp_valid_i,
  input logic        rsp_ready_i,
  input resp_desc_t  rsp_data_i
);

  rxd_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rxd_valid_i && !rxd_ready_i |=> rxd_valid_i && $stable(rxd_data_i))
    else $error("Receive dword dropped or changed while the queue stalled");

  rsp_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_data_i))
    else $error("Response dropped or changed while the queue stalled");

  tx_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_valid_i && !tx_ready_i |=> tx_valid_i && $stable(tx_byte_i))
    else $error("Outgoing byte dropped or changed before tx_ready_i");

  // An idle engine starts no transfer while disabled
  disabled_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !enable_i && (state_i == AwaitStart) |=> state_i == AwaitStart)
    else $error("Engine left AwaitStart while disabled");

  reset_a: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !acq_ready_i && !tx_valid_i && !rxd_valid_i && !rsp_valid_i)
    else $error("Engine outputs not idle on reset release");

endmodule

bind flow_standby_i2c i3c_standby_sva u_sva (
  .clk_i,
  .rst_ni,
  .enable_i,
  .state_i(state_q),
  .acq_ready_i(acq_ready_o),
  .tx_valid_i(tx_valid_o),
  .tx_ready_i,
  .tx_byte_i(tx_byte_o),
  .rxd_valid_i(tti.rxd_valid),
  .rxd_ready_i(tti.rxd_ready),
  .rxd_data_i(tti.rxd_data),
  .rsp_valid_i(tti.rsp_valid),
  .rsp_ready_i(tti.rsp_ready),
  .rsp_data_i(tti.rsp_data)
);

// ==== i3c_standby_top.sv ====
// I3C standby bridge top: flow engine, TTI queues and CSRs on plain ports
`timescale 1ns/10ps
`include "i3c_standby_params.svh"

module i3c_standby_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // I2C target acquisition and outgoing bytes
  input  logic                  acq_valid_i,
  output logic                  acq_ready_o,
  input  logic [`ACQ_WIDTH-1:0] acq_data_i,
  output logic                  tx_valid_o,
  input  logic                  tx_ready_i,
  output logic [7:0]            tx_byte_o,
  // Software queues
  input  logic                  cmd_valid_i,
  output logic                  cmd_ready_o,
  input  logic [15:0]           cmd_len_i,
  input  logic                  txd_valid_i,
  output logic                  txd_ready_o,
  input  logic [31:0]           txd_data_i,
  output logic                  rx_valid_o,
  input  logic                  rx_ready_i,
  output logic [31:0]           rx_data_o,
  output logic                  resp_valid_o,
  input  logic                  resp_ready_i,
  output logic [15:0]           resp_len_o,
  output logic                  resp_is_read_o,
  // Register port
  input  logic                  reg_we_i,
  input  logic [1:0]            reg_addr_i,
  input  logic [31:0]           reg_wdata_i,
  output logic [31:0]           reg_rdata_o,
  output logic                  err_o
);
  logic enable;
  logic err_clear;
  logic engine_err;
  logic xfer_done;

  tti_if tti ();

  flow_standby_i2c u_flow (
    .clk_i, .rst_ni,
    .acq_valid_i, .acq_ready_o, .acq_data_i,
    .tx_valid_o, .tx_ready_i, .tx_byte_o,
    .tti(tti.engine),
    .enable_i(enable), .err_clear_i(err_clear),
    .err_o(engine_err), .xfer_done_o(xfer_done)
  );

  tti_queues u_queues (
    .clk_i, .rst_ni,
    .tti(tti.queues),
    .cmd_valid_i, .cmd_ready_o, .cmd_len_i,
    .txd_valid_i, .txd_ready_o, .txd_data_i,
    .rx_valid_o, .rx_ready_i, .rx_data_o,
    .resp_valid_o, .resp_ready_i, .resp_len_o, .resp_is_read_o
  );

  standby_csr u_csr (
    .clk_i, .rst_ni,
    .reg_we_i, .reg_addr_i, .reg_wdata_i, .reg_rdata_o,
    .err_i(engine_err), .xfer_done_i(xfer_done),
    .enable_o(enable), .err_clear_o(err_clear), .irq_o(err_o)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator, run, and pass only if the testbench reports success
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module tb_i3c_standby -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "TESTS PASSED" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

// ==== standby_csr.sv ====
// Standby CSRs: engine enable, sticky error with clear, completed-transfer counter
`timescale 1ns/10ps
`include "i3c_standby_params.svh"

module standby_csr (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        reg_we_i,
  input  logic [1:0]  reg_addr_i,
  input  logic [31:0] reg_wdata_i,
  output logic [31:0] reg_rdata_o,
  input  logic        err_i,
  input  logic        xfer_done_i,
  output logic        enable_o,
  output logic        err_clear_o,
  output logic        irq_o
);
  logic        enable_q;
  logic        err_q;
  logic [15:0] xfer_cnt_q;
  logic        ctrl_wr;

  assign ctrl_wr     = reg_we_i && (reg_addr_i == `REG_CTRL);
  // Bit 1 of CTRL is write-one-to-clear, lasting as long as the write
  assign err_clear_o = ctrl_wr && reg_wdata_i[1];
  assign enable_o    = enable_q;
  assign irq_o       = err_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q   <= 1'b0;
      err_q      <= 1'b0;
      xfer_cnt_q <= '0;
    end else begin
      if (ctrl_wr) begin
        enable_q <= reg_wdata_i[0];
      end
      if (err_clear_o) begin
        err_q <= 1'b0;
      end else if (err_i) begin
        err_q <= 1'b1;
      end
      if (xfer_done_i) begin
        xfer_cnt_q <= xfer_cnt_q + 16'd1;
      end
    end
  end

  always_comb begin
    case (reg_addr_i)
      `REG_CTRL:     reg_rdata_o = {31'd0, enable_q};
      `REG_STATUS:   reg_rdata_o = {31'd0, err_q};
      `REG_XFER_CNT: reg_rdata_o = {16'd0, xfer_cnt_q};
      default:       reg_rdata_o = '0;
    endcase
  end

endmodule

// ==== sync_fifo.sv ====
// Synchronous valid/ready FIFO with occupancy count
`timescale 1ns/10ps

module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 8
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       wvalid_i,
  output logic                       wready_o,
  input  logic [WIDTH-1:0]           wdata_i,
  output logic                       rvalid_o,
  input  logic                       rready_i,
  output logic [WIDTH-1:0]           rdata_o,
  output logic [$clog2(DEPTH+1)-1:0] count_o
);
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wptr_q;
  logic [AW-1:0]    rptr_q;
  logic [CW-1:0]    count_q;
  logic             wr_en;
  logic             rd_en;

  assign wready_o = (count_q != CW'(DEPTH));
  assign rvalid_o = (count_q != '0);
  assign rdata_o  = mem[rptr_q];
  assign count_o  = count_q;

  assign wr_en = wvalid_i & wready_o;
  assign rd_en = rvalid_o & rready_i;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[wptr_q] <= wdata_i;
    end
  end

  // Pointers wrap explicitly so DEPTH need not be a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (wr_en) begin
        wptr_q <= (wptr_q == AW'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (rd_en) begin
        rptr_q <= (rptr_q == AW'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      end
      if (wr_en && !rd_en) begin
        count_q <= count_q + 1'b1;
      end else if (rd_en && !wr_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== tb.f ====
+incdir+.
i3c_standby_pkg.sv
tti_if.sv
sync_fifo.sv
tti_queues.sv
flow_standby_i2c.sv
standby_csr.sv
i3c_standby_top.sv
i3c_standby_sva.sv
tb_i3c_standby.sv

// ==== tb_i3c_standby.sv ====
// Testbench for the I3C standby bridge covering write, read, error, back-pressure and disable
`timescale 1ns/10ps
`include "i3c_standby_params.svh"

module tb_i3c_standby
  import i3c_standby_pkg::*;
();
  typedef enum logic [1:0] {RowWrite, RowRead, RowReadZero, RowDisabled} row_kind_e;

  typedef struct packed {
    row_kind_e   kind;
    logic [15:0] len;
    logic        bp;
  } row_t;

  localparam int NumRows   = 10;
  localparam int WaitLimit = 400;

  // Kind, length in bytes (cycles for a disabled row), back-pressure flag
  row_t rows [NumRows] = '{
    '{RowWrite,    16'd1,  1'b0},
    '{RowWrite,    16'd6,  1'b0},
    '{RowRead,     16'd4,  1'b0},
    '{RowWrite,    16'd11, 1'b0},
    '{RowRead,     16'd9,  1'b0},
    '{RowWrite,    16'd40, 1'b1},
    '{RowReadZero, 16'd0,  1'b0},
    '{RowWrite,    16'd8,  1'b0},
    '{RowDisabled, 16'd12, 1'b0},
    '{RowRead,     16'd7,  1'b0}
  };
  string kind_names [4] = '{"write", "read", "read-zero", "disabled"};

  logic                  clk_i;
  logic                  rst_ni;
  logic                  acq_valid_i;
  logic                  acq_ready_o;
  logic [`ACQ_WIDTH-1:0] acq_data_i;
  logic                  tx_valid_o;
  logic                  tx_ready_i;
  logic [7:0]            tx_byte_o;
  logic                  cmd_valid_i;
  logic                  cmd_ready_o;
  logic [15:0]           cmd_len_i;
  logic                  txd_valid_i;
  logic                  txd_ready_o;
  logic [31:0]           txd_data_i;
  logic                  rx_valid_o;
  logic                  rx_ready_i;
  logic [31:0]           rx_data_o;
  logic                  resp_valid_o;
  logic                  resp_ready_i;
  logic [15:0]           resp_len_o;
  logic                  resp_is_read_o;
  logic                  reg_we_i;
  logic [1:0]            reg_addr_i;
  logic [31:0]           reg_wdata_i;
  logic [31:0]           reg_rdata_o;
  logic                  err_o;

  logic [31:0] rand_state = 32'h34742970;
  logic [7:0]  payload [$];
  logic [7:0]  tx_seen [$];
  logic [31:0] rx_seen [$];
  int          errors;

  i3c_standby_top u_i3c_standby_top (.*);

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic void fill_payload(input int len);
    payload.delete();
    for (int i = 0; i < len; i++) begin
      rand_state = xorshift32(rand_state);
      payload.push_back(rand_state[7:0]);
    end
  endfunction

  // Dword k of the payload, first byte in bits 7:0, missing bytes zero
  function automatic logic [31:0] pack_dword(input int k);
    logic [31:0] dw;
    dw = '0;
    for (int b = 0; b < 4; b++) begin
      if (4 * k + b < payload.size())
        dw[8*b +: 8] = payload[4*k+b];
    end
    return dw;
  endfunction

  task automatic expect_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic expect_true(input logic ok, input string what);
    assert (ok) else begin
      $display("Failure at %0t ns: %s", $time, what);
      errors++;
    end
  endtask

  // All drivers start and end on a falling edge, outputs are sampled 2 ns later
  task automatic send_acq(input acq_id_e id, input logic [7:0] data);
    int   waited;
    logic taken;
    waited = 0;
    taken = 1'b0;
    acq_valid_i = 1'b1;
    acq_data_i = {id, data};
    while (!taken && waited < WaitLimit) begin
      #2;
      taken = acq_ready_o;
      @(negedge clk_i);
      waited++;
    end
    acq_valid_i = 1'b0;
    expect_true(taken, "acquisition event was never accepted");
  endtask

  task automatic push_cmd(input logic [15:0] len);
    cmd_valid_i = 1'b1;
    cmd_len_i = len;
    #2;
    expect_true(cmd_ready_o, "command queue refused a descriptor");
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
  endtask

  task automatic push_txd(input logic [31:0] data);
    txd_valid_i = 1'b1;
    txd_data_i = data;
    #2;
    expect_true(txd_ready_o, "transmit queue refused a dword");
    @(negedge clk_i);
    txd_valid_i = 1'b0;
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
    reg_we_i = 1'b1;
    reg_addr_i = addr;
    reg_wdata_i = data;
    @(negedge clk_i);
    reg_we_i = 1'b0;
  endtask

  task automatic read_reg(input logic [1:0] addr, output logic [31:0] data);
    reg_addr_i = addr;
    #2;
    data = reg_rdata_o;
    @(negedge clk_i);
  endtask

  // Holds the receive queue stalled for hold cycles, then drains count dwords
  task automatic collect_rx(input int count, input int hold);
    int waited;
    waited = 0;
    repeat (hold) @(negedge clk_i);
    rx_ready_i = 1'b1;
    while (rx_seen.size() < count && waited < WaitLimit) begin
      #2;
      if (rx_valid_o)
        rx_seen.push_back(rx_data_o);
      @(negedge clk_i);
      waited++;
    end
    rx_ready_i = 1'b0;
    expect_true(rx_seen.size() == count, "receive dwords missing");
  endtask

  task automatic collect_tx(input int count);
    int waited;
    waited = 0;
    tx_ready_i = 1'b1;
    while (tx_seen.size() < count && waited < WaitLimit) begin
      #2;
      if (tx_valid_o)
        tx_seen.push_back(tx_byte_o);
      @(negedge clk_i);
      waited++;
    end
    tx_ready_i = 1'b0;
    expect_true(tx_seen.size() == count, "read bytes missing on the I2C side");
  endtask

  task automatic expect_response(input int len, input logic is_read);
    int   waited;
    logic got;
    waited = 0;
    got = 1'b0;
    resp_ready_i = 1'b1;
    while (!got && waited < WaitLimit) begin
      #2;
      if (resp_valid_o) begin
        got = 1'b1;
        expect_equal("resp_len_o", 32'(resp_len_o), 32'(len));
        expect_equal("resp_is_read_o", 32'(resp_is_read_o), 32'(is_read));
      end
      @(negedge clk_i);
      waited++;
    end
    resp_ready_i = 1'b0;
    expect_true(got, "no response descriptor arrived");
  endtask

  task automatic run_write(input int len, input logic bp);
    int n_dw;
    fill_payload(len);
    rx_seen.delete();
    n_dw = (len + 3) / 4;
    fork
      begin
        send_acq(AcqStart, 8'hA0);
        foreach (payload[i])
          send_acq(AcqData, payload[i]);
        send_acq(AcqStop, 8'h00);
      end
      collect_rx(n_dw, bp ? 4 * len : 0);
    join
    for (int k = 0; k < n_dw; k++)
      expect_equal("rx_data_o", rx_seen[k], pack_dword(k));
    expect_response(len, 1'b0);
    expect_equal("rx_valid_o", 32'(rx_valid_o), 32'd0);
    expect_equal("err_o", 32'(err_o), 32'd0);
  endtask

  task automatic run_read(input int len);
    fill_payload(len);
    tx_seen.delete();
    push_cmd(16'(len));
    for (int k = 0; k < (len + 3) / 4; k++)
      push_txd(pack_dword(k));
    send_acq(AcqStart, 8'hA1);
    collect_tx(len);
    foreach (payload[i])
      expect_equal("tx_byte_o", 32'(tx_seen[i]), 32'(payload[i]));
    send_acq(AcqStop, 8'h00);
    expect_response(len, 1'b1);
  endtask

  task automatic run_read_zero();
    logic [31:0] status;
    int          waited;
    push_cmd(16'd0);
    send_acq(AcqStart, 8'hA1);
    waited = 0;
    while (!err_o && waited < WaitLimit) begin
      @(negedge clk_i);
      waited++;
    end
    read_reg(`REG_STATUS, status);
    expect_equal("err_o", 32'(err_o), 32'd1);
    expect_equal("STATUS", status, 32'd1);
    // Keep enable set while clearing the error
    write_reg(`REG_CTRL, 32'h3);
    read_reg(`REG_STATUS, status);
    expect_equal("err_o", 32'(err_o), 32'd0);
    expect_equal("STATUS", status, 32'd0);
  endtask

  task automatic run_disabled(input int cycles);
    write_reg(`REG_CTRL, 32'h0);
    acq_valid_i = 1'b1;
    acq_data_i = {AcqStart, 8'hA0};
    repeat (cycles) begin
      #2;
      expect_equal("acq_ready_o", 32'(acq_ready_o), 32'd0);
      @(negedge clk_i);
    end
    acq_valid_i = 1'b0;
    write_reg(`REG_CTRL, 32'h1);
  endtask

  initial begin
    logic [31:0] count;
    int          start;
    int          rows_failed;
    int          expected_done;
    acq_valid_i = 1'b0;
    acq_data_i = '0;
    tx_ready_i = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_len_i = '0;
    txd_valid_i = 1'b0;
    txd_data_i = '0;
    rx_ready_i = 1'b0;
    resp_ready_i = 1'b0;
    reg_we_i = 1'b0;
    reg_addr_i = '0;
    reg_wdata_i = '0;
    rst_ni = 1'b0;
    errors = 0;
    rows_failed = 0;
    expected_done = 0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    write_reg(`REG_CTRL, 32'h1);
    for (int r = 0; r < NumRows; r++) begin
      start = errors;
      case (rows[r].kind)
        RowWrite:    run_write(int'(rows[r].len), rows[r].bp);
        RowRead:     run_read(int'(rows[r].len));
        RowReadZero: run_read_zero();
        default:     run_disabled(int'(rows[r].len));
      endcase
      // Only write and read rows end with a response
      if (rows[r].kind == RowWrite || rows[r].kind == RowRead)
        expected_done++;
      if (errors != start)
        rows_failed++;
      $display("Row %0d %s len %0d: %s", r, kind_names[rows[r].kind], rows[r].len,
               (errors == start) ? "passed" : "failed");
    end
    read_reg(`REG_XFER_CNT, count);
    expect_equal("XFER_CNT", count, 32'(expected_done));
    $display("Summary: %0d rows, %0d failed, %0d errors", NumRows, rows_failed, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  // Limit scales with the table size and its longest row
  initial begin
    int max_len;
    max_len = 1;
    foreach (rows[i]) begin
      if (int'(rows[i].len) > max_len)
        max_len = int'(rows[i].len);
    end
    repeat (NumRows * max_len * 40) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the run did not finish", NumRows * max_len * 40);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== tti_if.sv ====
// TTI channel bundle: command, transmit, receive and response handshakes
`timescale 1ns/10ps

interface tti_if
  import i3c_standby_pkg::*;
();
  logic        cmd_valid;
  logic        cmd_ready;
  cmd_desc_t   cmd_data;

  logic        txd_valid;
  logic        txd_ready;
  logic [31:0] txd_data;

  logic        rxd_valid;
  logic        rxd_ready;
  logic [31:0] rxd_data;

  logic        rsp_valid;
  logic        rsp_ready;
  resp_desc_t  rsp_data;

  // Flow engine side
  modport engine (
    input  cmd_valid, cmd_data, txd_valid, txd_data, rxd_ready, rsp_ready,
    output cmd_ready, txd_ready, rxd_valid, rxd_data, rsp_valid, rsp_data
  );

  // Queue side
  modport queues (
    output cmd_valid, cmd_data, txd_valid, txd_data, rxd_ready, rsp_ready,
    input  cmd_ready, txd_ready, rxd_valid, rxd_data, rsp_valid, rsp_data
  );

endinterface

// ==== tti_queues.sv ====
// TTI queues: command, transmit, receive and response FIFOs beside the engine
`timescale 1ns/10ps
`include "i3c_standby_params.svh"

module tti_queues
  import i3c_standby_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  tti_if.queues       tti,
  input  logic        cmd_valid_i,
  output logic        cmd_ready_o,
  input  logic [15:0] cmd_len_i,
  input  logic        txd_valid_i,
  output logic        txd_ready_o,
  input  logic [31:0] txd_data_i,
  output logic        rx_valid_o,
  input  logic        rx_ready_i,
  output logic [31:0] rx_data_o,
  output logic        resp_valid_o,
  input  logic        resp_ready_i,
  output logic [15:0] resp_len_o,
  output logic        resp_is_read_o
);
  localparam int Depth = `QUEUE_DEPTH;

  cmd_desc_t  cmd_wdata;
  resp_desc_t rsp_rdata;

  assign cmd_wdata.data_length = cmd_len_i;
  assign resp_len_o            = rsp_rdata.data_length;
  assign resp_is_read_o        = rsp_rdata.is_read;

  // Software to engine
  sync_fifo #(.WIDTH($bits(cmd_desc_t)), .DEPTH(Depth)) u_cmd_fifo (
    .clk_i, .rst_ni,
    .wvalid_i(cmd_valid_i), .wready_o(cmd_ready_o), .wdata_i(cmd_wdata),
    .rvalid_o(tti.cmd_valid), .rready_i(tti.cmd_ready), .rdata_o(tti.cmd_data),
    .count_o()
  );

  sync_fifo #(.WIDTH(32), .DEPTH(Depth)) u_txd_fifo (
    .clk_i, .rst_ni,
    .wvalid_i(txd_valid_i), .wready_o(txd_ready_o), .wdata_i(txd_data_i),
    .rvalid_o(tti.txd_valid), .rready_i(tti.txd_ready), .rdata_o(tti.txd_data),
    .count_o()
  );

  // Engine to software
  sync_fifo #(.WIDTH(32), .DEPTH(Depth)) u_rxd_fifo (
    .clk_i, .rst_ni,
    .wvalid_i(tti.rxd_valid), .wready_o(tti.rxd_ready), .wdata_i(tti.rxd_data),
    .rvalid_o(rx_valid_o), .rready_i(rx_ready_i), .rdata_o(rx_data_o),
    .count_o()
  );

  sync_fifo #(.WIDTH($bits(resp_desc_t)), .DEPTH(Depth)) u_rsp_fifo (
    .clk_i, .rst_ni,
    .wvalid_i(tti.rsp_valid), .wready_o(tti.rsp_ready), .wdata_i(tti.rsp_data),
    .rvalid_o(resp_valid_o), .rready_i(resp_ready_i), .rdata_o(rsp_rdata),
    .count_o()
  );

endmodule
